// File: design/audio_pkg.sv
`default_nettype none

package audio_pkg;

	localparam int SAMPLE_W = 32;
	localparam int WB_DW = 32;

	typedef enum logic [2:0] {
		NOTE_OFF     = 3'd0,
		NOTE_DO      = 3'd1,
		NOTE_MI      = 3'd2,
		NOTE_SO      = 3'd3,
		NOTE_DO_HIGH = 3'd4
	} note_t;

	// Half-period codes per note, codes 5 to 7 stay silent
	localparam logic [7:0] NOTE_HALF_CODE [8] = '{
		8'd0,
		8'd93,
		8'd73,
		8'd62,
		8'd46,
		8'd0,
		8'd0,
		8'd0
	};

	localparam logic signed [SAMPLE_W-1:0] TONE_AMP = 32'sd10000000;

	// Word addresses on the host port
	localparam logic REG_CTRL = 1'b0;
	localparam logic REG_FRAMES = 1'b1;

endpackage

`default_nettype wire

// File: design/audio_frame_if.sv
`default_nettype none

interface audio_frame_if;
	import audio_pkg::*;

	logic valid;
	logic ready;
	logic [SAMPLE_W-1:0] left;
	logic [SAMPLE_W-1:0] right;

	modport src (
		output valid,
		output left,
		output right,
		input ready
	);

	modport snk (
		input valid,
		input left,
		input right,
		output ready
	);

endinterface

`default_nettype wire

// File: design/tone_regs.sv
`default_nettype none

module tone_regs (
	input wire logic clk,
	input wire logic resetn,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic wb_adr,
	input wire logic [audio_pkg::WB_DW-1:0] wb_dat_i,
	input wire logic [3:0] wb_sel,
	input wire logic frame_done,
	output logic wb_ack,
	output logic [audio_pkg::WB_DW-1:0] wb_dat_o,
	output logic enable,
	output audio_pkg::note_t note
);
	import audio_pkg::*;

	logic req;
	logic ctrl_wr;
	logic [WB_DW-1:0] frame_cnt;

	// A new request only while no ack is outstanding
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign ctrl_wr = req && wb_we && wb_sel[0] && (wb_adr == REG_CTRL);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	// Write lands together with the ack
	always_ff @(posedge clk) begin
		if (!resetn) begin
			enable <= 1'b0;
			note <= NOTE_OFF;
		end else if (ctrl_wr) begin
			enable <= wb_dat_i[0];
			note <= note_t'(wb_dat_i[3:1]);
		end
	end

	// Mixed frame count, wraps
	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame_cnt <= '0;
		end else if (frame_done) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			case (wb_adr)
				REG_CTRL: begin
					wb_dat_o <= {{(WB_DW-4){1'b0}}, note, enable};
				end
				REG_FRAMES: begin
					wb_dat_o <= frame_cnt;
				end
				default: begin
					wb_dat_o <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/tone_mixer.sv
`default_nettype none

module tone_mixer #(
	parameter int PERIOD_SHIFT = 11
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic enable,
	input wire audio_pkg::note_t note,
	audio_frame_if.snk adc_frame,
	audio_frame_if.src dac_frame,
	output logic frame_done
);
	import audio_pkg::*;

	localparam int CNT_W = 8 + PERIOD_SHIFT;

	logic [CNT_W-1:0] half_len;
	logic [CNT_W-1:0] half_cnt;
	note_t note_q;
	logic phase;
	logic tone_on;
	logic signed [SAMPLE_W-1:0] tone;
	logic take;

	// Half period in clk cycles, minus one
	assign half_len = CNT_W'(NOTE_HALF_CODE[note]) << PERIOD_SHIFT;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			half_cnt <= '0;
			phase <= 1'b0;
			note_q <= NOTE_OFF;
		end else begin
			note_q <= note;
			if ((note != note_q) || (half_len == '0)) begin
				half_cnt <= '0;
			end else if (half_cnt == half_len) begin
				half_cnt <= '0;
				phase <= !phase;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	assign tone_on = enable && (half_len != '0);

	always_comb begin
		if (!tone_on) begin
			tone = '0;
		end else if (phase) begin
			tone = TONE_AMP;
		end else begin
			tone = -TONE_AMP;
		end
	end

	// Stall input only while the mixed frame waits
	assign adc_frame.ready = !(dac_frame.valid && !dac_frame.ready);
	assign take = adc_frame.valid && adc_frame.ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dac_frame.valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= take;
			if (take) begin
				dac_frame.valid <= 1'b1;
			end else if (dac_frame.ready) begin
				dac_frame.valid <= 1'b0;
			end
		end
	end

	// Same tone on both channels, 32-bit wrap
	always_ff @(posedge clk) begin
		if (take) begin
			dac_frame.left <= adc_frame.left + tone;
			dac_frame.right <= adc_frame.right + tone;
		end
	end

endmodule

`default_nettype wire

// File: design/i2s_codec_if_ctrl.sv
`default_nettype none

module i2s_codec_if_ctrl #(
	parameter int BCLK_DIV = 4
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic aud_adcdat,
	output logic aud_bclk,
	output logic aud_lrck,
	output logic aud_dacdat,
	audio_frame_if.src adc_frame,
	audio_frame_if.snk dac_frame
);
	import audio_pkg::*;

	localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
	localparam int FRAME_W = 2 * SAMPLE_W;

	logic [DIV_W-1:0] div_cnt;
	logic div_end;
	logic bclk_rise;
	logic bclk_fall;
	logic [5:0] bit_cnt;
	logic [5:0] bit_nxt;
	logic rx_armed;
	logic rx_done;
	logic [FRAME_W-1:0] rx_sr;
	logic [FRAME_W-1:0] tx_sr;
	logic [FRAME_W-1:0] dac_buf;

	assign div_end = (div_cnt == DIV_W'(BCLK_DIV - 1));
	assign bclk_rise = div_end && !aud_bclk;
	assign bclk_fall = div_end && aud_bclk;
	assign bit_nxt = bit_cnt + 6'd1;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			aud_bclk <= 1'b0;
		end else if (div_end) begin
			div_cnt <= '0;
			aud_bclk <= !aud_bclk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// bit_cnt is the bit on the data lines, 0 is the left MSB
	always_ff @(posedge clk) begin
		if (!resetn) begin
			bit_cnt <= 6'd63;
			aud_lrck <= 1'b0;
		end else if (bclk_fall) begin
			bit_cnt <= bit_nxt;
			// Word select leads each channel MSB by one bit
			aud_lrck <= (bit_nxt >= 6'd31) && (bit_nxt != 6'd63);
		end
	end

	always_ff @(posedge clk) begin
		if (bclk_rise) begin
			rx_sr <= {rx_sr[FRAME_W-2:0], aud_adcdat};
		end
	end

	// First frame after reset is partial, skip it
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_armed <= 1'b0;
			rx_done <= 1'b0;
		end else begin
			if (bclk_rise && (bit_cnt == 6'd0)) begin
				rx_armed <= 1'b1;
			end
			rx_done <= bclk_rise && (bit_cnt == 6'd63) && rx_armed;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			adc_frame.valid <= 1'b0;
		end else if (rx_done) begin
			adc_frame.valid <= 1'b1;
		end else if (adc_frame.ready) begin
			adc_frame.valid <= 1'b0;
		end
	end

	// A pending frame is overwritten by the next one
	always_ff @(posedge clk) begin
		if (rx_done) begin
			adc_frame.left <= rx_sr[FRAME_W-1:SAMPLE_W];
			adc_frame.right <= rx_sr[SAMPLE_W-1:0];
		end
	end

	assign dac_frame.ready = 1'b1;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dac_buf <= '0;
		end else if (dac_frame.valid && dac_frame.ready) begin
			dac_buf <= {dac_frame.left, dac_frame.right};
		end
	end

	// Reload on the lrck fall, old frame's LSB still goes out
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_sr <= '0;
			aud_dacdat <= 1'b0;
		end else if (bclk_fall) begin
			aud_dacdat <= tx_sr[FRAME_W-1];
			if (bit_nxt == 6'd63) begin
				tx_sr <= dac_buf;
			end else begin
				tx_sr <= tx_sr << 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/audio_top.sv
`default_nettype none

module audio_top #(
	parameter int PERIOD_SHIFT = 11,
	parameter int BCLK_DIV = 4
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic wb_adr,
	input wire logic [audio_pkg::WB_DW-1:0] wb_dat_i,
	input wire logic [3:0] wb_sel,
	output wire logic wb_ack,
	output wire logic [audio_pkg::WB_DW-1:0] wb_dat_o,
	input wire logic aud_adcdat,
	output wire logic aud_bclk,
	output wire logic aud_lrck,
	output wire logic aud_dacdat
);
	import audio_pkg::*;

	logic enable;
	note_t note;
	logic frame_done;

	audio_frame_if adc_frame ();
	audio_frame_if dac_frame ();

	tone_regs tone_regs_i (
		.clk        (clk),
		.resetn     (resetn),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_sel     (wb_sel),
		.frame_done (frame_done),
		.wb_ack     (wb_ack),
		.wb_dat_o   (wb_dat_o),
		.enable     (enable),
		.note       (note)
	);

	tone_mixer #(
		.PERIOD_SHIFT (PERIOD_SHIFT)
	) tone_mixer_i (
		.clk        (clk),
		.resetn     (resetn),
		.enable     (enable),
		.note       (note),
		.adc_frame  (adc_frame.snk),
		.dac_frame  (dac_frame.src),
		.frame_done (frame_done)
	);

	i2s_codec_if_ctrl #(
		.BCLK_DIV (BCLK_DIV)
	) i2s_codec_if_ctrl_i (
		.clk        (clk),
		.resetn     (resetn),
		.aud_adcdat (aud_adcdat),
		.aud_bclk   (aud_bclk),
		.aud_lrck   (aud_lrck),
		.aud_dacdat (aud_dacdat),
		.adc_frame  (adc_frame.src),
		.dac_frame  (dac_frame.snk)
	);

endmodule

`default_nettype wire

// File: sim/audio_assert.sv
`default_nettype none

module audio_assert #(
	parameter int BCLK_DIV = 4
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic aud_bclk,
	input wire logic aud_lrck
);
	timeunit 1ns;
	timeprecision 1ps;

	logic bclk_q;
	logic lrck_q;
	logic seen_edge;
	int hold_cnt;
	int fall_cnt;
	logic bclk_chg;
	logic bclk_fell;
	logic lrck_chg;

	assign bclk_chg = aud_bclk != bclk_q;
	assign bclk_fell = bclk_q && !aud_bclk;
	assign lrck_chg = aud_lrck != lrck_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bclk_q <= 1'b0;
			lrck_q <= 1'b0;
			seen_edge <= 1'b0;
			hold_cnt <= 0;
			fall_cnt <= 0;
		end else begin
			bclk_q <= aud_bclk;
			lrck_q <= aud_lrck;
			if (bclk_chg) begin
				seen_edge <= 1'b1;
				hold_cnt <= 0;
			end else begin
				hold_cnt <= hold_cnt + 1;
			end
			// Falls of bclk since the last word clock change
			if (lrck_chg) begin
				fall_cnt <= 0;
			end else if (bclk_fell) begin
				fall_cnt <= fall_cnt + 1;
			end
		end
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |=> !wb_ack) else $error("ack held longer than one cycle");

	ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |-> (wb_cyc && wb_stb && $past(wb_cyc && wb_stb)))
		else $error("ack without a request");

	req_gets_ack: assert property (@(posedge clk) disable iff (!resetn)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack) else $error("ack late");

	bclk_period: assert property (@(posedge clk) disable iff (!resetn)
		(seen_edge && bclk_chg) |-> (hold_cnt == BCLK_DIV - 1))
		else $error("bit clock half period wrong");

	lrck_on_fall: assert property (@(posedge clk) disable iff (!resetn)
		lrck_chg |-> bclk_fell) else $error("word clock moved off falling bclk");

	lrck_period: assert property (@(posedge clk) disable iff (!resetn)
		lrck_chg |-> (fall_cnt == 31)) else $error("word clock not 32 bit clocks");

endmodule

bind audio_top audio_assert #(
	.BCLK_DIV (BCLK_DIV)
) audio_assert_i (
	.clk      (clk),
	.resetn   (resetn),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_ack   (wb_ack),
	.aud_bclk (aud_bclk),
	.aud_lrck (aud_lrck)
);

`default_nettype wire

// File: sim/audio_tb.sv
`default_nettype none

module audio_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD_SHIFT = 3;
	localparam int BCLK_DIV = 2;
	localparam int MAX_FRAMES = 64;
	localparam int FRAME_LAG = 2;
	localparam int TIMEOUT_CYCLES = 40 * 256 + 2000;
	localparam logic [31:0] AMP = 32'd10000000;

	logic clk;
	logic resetn;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_adr;
	logic [31:0] wb_dat_i;
	logic [3:0] wb_sel;
	logic wb_ack;
	logic [31:0] wb_dat_o;
	logic aud_adcdat = 1'b0;
	logic aud_bclk;
	logic aud_lrck;
	logic aud_dacdat;

	// Serial models
	logic bclk_q;
	logic [5:0] bit_idx;
	logic running;
	int adc_per;
	int dac_per;
	int cycles;
	logic [63:0] adc_cur;
	logic [63:0] dac_sr;
	logic [31:0] adc_l [MAX_FRAMES];
	logic [31:0] adc_r [MAX_FRAMES];
	logic [31:0] dac_l [MAX_FRAMES];
	logic [31:0] dac_r [MAX_FRAMES];

	// Tone statistics
	int pos_seen;
	int neg_seen;
	int flips;
	logic last_sign;

	audio_top #(
		.PERIOD_SHIFT (PERIOD_SHIFT),
		.BCLK_DIV     (BCLK_DIV)
	) audio_top_i (
		.clk        (clk),
		.resetn     (resetn),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_sel     (wb_sel),
		.wb_ack     (wb_ack),
		.wb_dat_o   (wb_dat_o),
		.aud_adcdat (aud_adcdat),
		.aud_bclk   (aud_bclk),
		.aud_lrck   (aud_lrck),
		.aud_dacdat (aud_dacdat)
	);

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = !clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_error("Timeout waiting for the DUT");
		end
	end

	// ADC source and DAC capture, both locked to the DUT clocks
	always @(posedge clk) begin
		logic [5:0] nxt;
		logic [5:0] ahead;
		logic [63:0] frame;
		if (!resetn) begin
			bclk_q <= 1'b0;
			bit_idx <= 6'd63;
			running <= 1'b0;
			adc_per <= -1;
			dac_per <= -1;
			aud_adcdat <= 1'b0;
			dac_sr <= '0;
		end else begin
			bclk_q <= aud_bclk;
			if (bclk_q && !aud_bclk) begin
				nxt = bit_idx + 6'd1;
				// Word select shows the channel of the following bit
				ahead = nxt + 6'd1;
				bit_idx <= nxt;
				if (aud_lrck != ahead[5]) begin
					report_mismatch("word clock out of step with the bit clock");
				end
				if (nxt == 6'd0) begin
					frame = {$urandom, $urandom};
					adc_cur <= frame;
					adc_l[adc_per + 1] <= frame[63:32];
					adc_r[adc_per + 1] <= frame[31:0];
					adc_per <= adc_per + 1;
					running <= 1'b1;
					aud_adcdat <= frame[63];
				end else begin
					aud_adcdat <= adc_cur[63 - nxt];
				end
			end
			if (!bclk_q && aud_bclk && running) begin
				frame = {dac_sr[62:0], aud_dacdat};
				dac_sr <= frame;
				if (bit_idx == 6'd63) begin
					dac_l[adc_per] <= frame[63:32];
					dac_r[adc_per] <= frame[31:0];
					dac_per <= adc_per;
				end
			end
		end
	end

	task automatic wb_access(input logic we, input logic adr, input logic [31:0] wdata,
			input logic [3:0] sel, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_i <= wdata;
		wb_sel <= sel;
		@(posedge clk);
		while (!wb_ack) begin
			waited++;
			if (waited > 8) begin
				report_error("No Wishbone ack from the DUT");
			end
			@(posedge clk);
		end
		rdata = wb_dat_o;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic write_reg(input logic adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_access(1'b1, adr, data, 4'hf, unused);
	endtask

	task automatic read_reg(input logic adr, output logic [31:0] data);
		wb_access(1'b0, adr, 32'h0, 4'hf, data);
	endtask

	task automatic next_capture(output int p);
		int last;
		last = dac_per;
		while (dac_per == last) begin
			@(posedge clk);
		end
		p = dac_per;
	endtask

	// DAC frame p carries ADC frame p - FRAME_LAG plus the tone
	task automatic check_frames(input int count, input bit tone);
		int p;
		logic [31:0] dl;
		logic [31:0] dr;
		for (int i = 0; i < count; i++) begin
			next_capture(p);
			if (p < FRAME_LAG) begin
				dl = dac_l[p];
				dr = dac_r[p];
			end else begin
				dl = dac_l[p] - adc_l[p - FRAME_LAG];
				dr = dac_r[p] - adc_r[p - FRAME_LAG];
			end
			if (!tone) begin
				assert (dl == 32'h0 && dr == 32'h0)
					else report_mismatch($sformatf("frame %0d loopback off by %h/%h", p, dl, dr));
			end else begin
				assert (dl == dr)
					else report_mismatch($sformatf("frame %0d channels differ %h/%h", p, dl, dr));
				assert (dl == AMP || dl == -AMP)
					else report_mismatch($sformatf("frame %0d tone value %h", p, dl));
				if (i > 0 && (dl == AMP) != last_sign) begin
					flips++;
				end
				last_sign = (dl == AMP);
				if (dl == AMP) begin
					pos_seen++;
				end else begin
					neg_seen++;
				end
			end
		end
	endtask

	task automatic skip_frames(input int count);
		int p;
		repeat (count) next_capture(p);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] cnt0;
		int flips_do;
		cycles = 0;
		void'($urandom(69));
		resetn <= 1'b0;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= 1'b0;
		wb_dat_i <= '0;
		wb_sel <= '0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		assert (!aud_bclk && !aud_lrck && !aud_dacdat && !wb_ack)
			else report_mismatch("outputs not low after reset");

		read_reg(1'b0, rd);
		assert (rd == 32'h0) else report_mismatch($sformatf("CTRL after reset %h", rd));
		read_reg(1'b1, rd);
		assert (rd == 32'h0) else report_mismatch($sformatf("frame count after reset %h", rd));

		// Enable low, note DO_HIGH, junk above bit 3
		write_reg(1'b0, 32'ha5a5_5a58);
		read_reg(1'b0, rd);
		assert (rd == 32'h8) else report_mismatch($sformatf("CTRL readback %h", rd));
		check_frames(3, 1'b0);

		// Enable high with the note off
		write_reg(1'b0, 32'h1);
		read_reg(1'b0, rd);
		assert (rd == 32'h1) else report_mismatch($sformatf("CTRL readback %h", rd));
		skip_frames(2);
		read_reg(1'b1, cnt0);
		check_frames(3, 1'b0);
		read_reg(1'b1, rd);
		assert (rd - cnt0 == 32'd3)
			else report_mismatch($sformatf("frame count grew by %0d", rd - cnt0));

		write_reg(1'b0, 32'h3);
		skip_frames(2);
		pos_seen = 0;
		neg_seen = 0;
		flips = 0;
		check_frames(10, 1'b1);
		if (pos_seen == 0 || neg_seen == 0) begin
			report_error("Tone did not show both signs");
		end
		flips_do = flips;

		write_reg(1'b0, 32'h9);
		skip_frames(2);
		flips = 0;
		check_frames(10, 1'b1);
		assert (flips > flips_do)
			else report_mismatch($sformatf("DO_HIGH flips %0d vs DO %0d", flips, flips_do));

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: audio_tone.f
design/audio_pkg.sv
design/audio_frame_if.sv
design/tone_regs.sv
design/tone_mixer.sv
design/i2s_codec_if_ctrl.sv
design/audio_top.sv
sim/audio_assert.sv
sim/audio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module audio_tb -f audio_tone.f -o audio_sim > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/audio_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
